// ==== source/csr_pkg.sv ====
// Shared definitions for the machine-mode CSR file.
// Holds CSR addresses, operation codes, privilege levels, the bundled
// request, trap and event structs, and the performance event indices.
// Every RTL file refers to these by scoped name.

package csr_pkg;

  // csr access operation, as decoded from the csr instruction
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'd0,
    CSR_OP_WRITE = 2'd1,
    CSR_OP_SET   = 2'd2,
    CSR_OP_CLEAR = 2'd3
  } csr_op_e;

  // only machine mode is implemented
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'd0,
    PRIV_LVL_M = 2'd3
  } priv_lvl_e;

  //////////////////////////////////////////////////////////////////////
  // csr addresses
  //////////////////////////////////////////////////////////////////////

  // machine trap setup and handling
  localparam logic [11:0] CSR_MSTATUS   = 12'h300;
  localparam logic [11:0] CSR_MISA      = 12'h301;
  localparam logic [11:0] CSR_MTVEC     = 12'h305;
  localparam logic [11:0] CSR_MEPC      = 12'h341;
  localparam logic [11:0] CSR_MCAUSE    = 12'h342;

  // identity, all read only
  localparam logic [11:0] CSR_MVENDORID = 12'hF11;
  localparam logic [11:0] CSR_MARCHID   = 12'hF12;
  localparam logic [11:0] CSR_MIMPID    = 12'hF13;
  localparam logic [11:0] CSR_MHARTID   = 12'hF14;
  localparam logic [11:0] CSR_UHARTID   = 12'h014;
  localparam logic [11:0] CSR_PRIVLV    = 12'hC10;

  // performance counters, 32 counter slots from the base
  localparam logic [11:0] CSR_PCER      = 12'h7A0;
  localparam logic [11:0] CSR_PCMR      = 12'h7A1;
  localparam logic [11:0] CSR_PCCR_ALL  = 12'h79F;
  localparam logic [11:0] CSR_PCCR_BASE = 12'h780;

  // mstatus field positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LO   = 11;
  localparam int MSTATUS_MPP_HI   = 12;

  //////////////////////////////////////////////////////////////////////
  // bundled signals
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic        access;
    logic [11:0] addr;
    logic [31:0] wdata;
    csr_op_e     op;
  } csr_req_t;

  typedef struct packed {
    logic      mie;
    logic      mpie;
    priv_lvl_e mpp;
  } mstatus_t;

  // strobes from the exception controller, one cycle each
  typedef struct packed {
    logic        save_cause;
    logic        restore_mret;
    logic        save_if;
    // id stage pc is also the fallback source
    logic        save_id;
    logic        load_event_ex;
    logic [5:0]  cause;
    logic [31:0] pc_if;
    logic [31:0] pc_id;
    logic [31:0] pc_ex;
  } trap_ctrl_t;

  // raw core events feeding the performance counters
  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic is_compressed;
    logic imiss;
    logic pc_set;
    logic jump;
    logic branch;
    logic branch_taken;
    logic ld_stall;
    logic mem_load;
    logic mem_store;
  } perf_event_t;

  // counter slot of each fixed event, external events follow
  localparam int EV_CYCLE        = 0;
  localparam int EV_INSTR        = 1;
  localparam int EV_LD_STALL     = 2;
  localparam int EV_IMISS        = 3;
  localparam int EV_LOAD         = 4;
  localparam int EV_STORE        = 5;
  localparam int EV_JUMP         = 6;
  localparam int EV_BRANCH       = 7;
  localparam int EV_BRANCH_TAKEN = 8;
  localparam int EV_COMPRESSED   = 9;
  localparam int N_FIXED_EVENTS  = 10;

  // counting enabled, saturation on
  localparam logic [1:0] PCMR_RESET = 2'd3;

endpackage

// ==== source/csr_op_unit.sv ====
// CSR operation merge.
// Combines the request write data with the current register value so
// that write, set and clear all become a plain register write.
// The current value is the read data already selected by the top level.

module csr_op_unit (
  input  csr_pkg::csr_req_t csr_req_i,
  input  logic [31:0]       rdata_i,
  output logic [31:0]       wdata_o,
  output logic              we_o
);

  always_comb begin
    wdata_o = csr_req_i.wdata;
    we_o    = 1'b1;

    case (csr_req_i.op)
      csr_pkg::CSR_OP_WRITE: begin
        wdata_o = csr_req_i.wdata;
      end
      // set bits given in wdata
      csr_pkg::CSR_OP_SET: begin
        wdata_o = csr_req_i.wdata | rdata_i;
      end
      // clear bits given in wdata
      csr_pkg::CSR_OP_CLEAR: begin
        wdata_o = rdata_i & ~csr_req_i.wdata;
      end
      // read only access
      default: begin
        we_o = 1'b0;
      end
    endcase
  end

endmodule

// ==== source/machine_trap_regs.sv ====
// Machine trap registers and machine CSR read decode.
// Holds mstatus, mepc and mcause, performs trap entry and MRET, and
// returns read data for all machine and identity CSRs.
// CSR writes use merged data from the operation unit.

module machine_trap_regs (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [11:0]          addr_i,
  input  logic [31:0]          wdata_i,
  input  logic                 we_i,
  input  csr_pkg::trap_ctrl_t  trap_i,
  input  logic [23:0]          boot_addr_i,
  input  logic [3:0]           core_id_i,
  input  logic [5:0]           cluster_id_i,
  output logic [31:0]          rdata_o,
  output logic [31:0]          epc_o,
  output logic [23:0]          tvec_o,
  output logic                 irq_enable_o,
  output logic                 csr_busy_o,
  output csr_pkg::priv_lvl_e   priv_lvl_o
);

  csr_pkg::mstatus_t mstatus_q, mstatus_n;
  logic [31:0]       mepc_q, mepc_n;
  logic [5:0]        mcause_q, mcause_n;
  logic [31:0]       exception_pc;
  logic [31:0]       hartid;

  // cluster id in 10:5, core id in 3:0
  assign hartid = {21'b0, cluster_id_i, 1'b0, core_id_i};

  //////////////////////////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata_o = '0;

    case (addr_i)
      csr_pkg::CSR_MSTATUS: begin
        rdata_o[csr_pkg::MSTATUS_MIE_BIT]  = mstatus_q.mie;
        rdata_o[csr_pkg::MSTATUS_MPIE_BIT] = mstatus_q.mpie;
        rdata_o[csr_pkg::MSTATUS_MPP_HI:csr_pkg::MSTATUS_MPP_LO] = mstatus_q.mpp;
      end
      // trap vector fixed to the boot address
      csr_pkg::CSR_MTVEC:   rdata_o = {boot_addr_i, 8'h0};
      csr_pkg::CSR_MEPC:    rdata_o = mepc_q;
      // interrupt flag lives in bit 31
      csr_pkg::CSR_MCAUSE:  rdata_o = {mcause_q[5], 26'b0, mcause_q[4:0]};
      csr_pkg::CSR_MHARTID: rdata_o = hartid;
      csr_pkg::CSR_UHARTID: rdata_o = hartid;
      csr_pkg::CSR_PRIVLV:  rdata_o = {30'b0, csr_pkg::PRIV_LVL_M};
      // misa and vendor, arch and impl ids read as zero
      csr_pkg::CSR_MISA,
      csr_pkg::CSR_MVENDORID,
      csr_pkg::CSR_MARCHID,
      csr_pkg::CSR_MIMPID:  rdata_o = '0;
      default:              rdata_o = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // next state, trap and mret win over csr writes
  //////////////////////////////////////////////////////////////////////

  // pc to save, ex stage load error first
  always_comb begin
    if (trap_i.load_event_ex) begin
      exception_pc = trap_i.pc_ex;
    end else if (trap_i.save_if) begin
      exception_pc = trap_i.pc_if;
    end else begin
      exception_pc = trap_i.pc_id;
    end
  end

  always_comb begin
    mstatus_n = mstatus_q;
    mepc_n    = mepc_q;
    mcause_n  = mcause_q;

    if (we_i) begin
      case (addr_i)
        // mpp stays machine mode, no other level exists
        csr_pkg::CSR_MSTATUS: begin
          mstatus_n.mie  = wdata_i[csr_pkg::MSTATUS_MIE_BIT];
          mstatus_n.mpie = wdata_i[csr_pkg::MSTATUS_MPIE_BIT];
          mstatus_n.mpp  = csr_pkg::PRIV_LVL_M;
        end
        csr_pkg::CSR_MEPC:   mepc_n   = wdata_i;
        csr_pkg::CSR_MCAUSE: mcause_n = {wdata_i[31], wdata_i[4:0]};
        default: ;
      endcase
    end

    if (trap_i.save_cause) begin
      // trap entry, M to M
      mstatus_n.mpie = mstatus_q.mie;
      mstatus_n.mie  = 1'b0;
      mstatus_n.mpp  = csr_pkg::PRIV_LVL_M;
      mepc_n         = exception_pc;
      mcause_n       = trap_i.cause;
    end else if (trap_i.restore_mret) begin
      mstatus_n.mie  = mstatus_q.mpie;
      mstatus_n.mpie = 1'b1;
      mstatus_n.mpp  = csr_pkg::PRIV_LVL_M;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q <= '{mie: 1'b0, mpie: 1'b0, mpp: csr_pkg::PRIV_LVL_M};
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      mstatus_q <= mstatus_n;
      mepc_q    <= mepc_n;
      mcause_q  <= mcause_n;
    end
  end

  // mret target and trap vector go straight to the core
  assign epc_o        = mepc_q;
  assign tvec_o       = boot_addr_i;
  assign irq_enable_o = mstatus_q.mie;
  assign priv_lvl_o   = csr_pkg::PRIV_LVL_M;

  // fetch must wait for a new mepc before mret
  assign csr_busy_o   = we_i && (addr_i == csr_pkg::CSR_MEPC);

endmodule

// ==== source/perf_config_regs.sv ====
// Performance counter configuration.
// PCER selects which events count, PCMR holds global enable (bit 0)
// and saturation (bit 1). Both steer the counter bank and are written
// with merged data from the operation unit.

module perf_config_regs #(
  parameter int N_PERF_COUNTERS = 12
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [11:0]                addr_i,
  input  logic                       access_i,
  input  logic [31:0]                wdata_i,
  input  logic                       we_i,
  output logic [N_PERF_COUNTERS-1:0] pcer_o,
  output logic [1:0]                 pcmr_o,
  output logic [31:0]                rdata_o
);

  logic [N_PERF_COUNTERS-1:0] pcer_q;
  logic [1:0]                 pcmr_q;
  logic                       is_pcer;
  logic                       is_pcmr;

  // only a real access touches the registers
  assign is_pcer = access_i && (addr_i == csr_pkg::CSR_PCER);
  assign is_pcmr = access_i && (addr_i == csr_pkg::CSR_PCMR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      pcmr_q <= csr_pkg::PCMR_RESET;
    end else begin
      if (is_pcer && we_i) begin
        pcer_q <= wdata_i[N_PERF_COUNTERS-1:0];
      end
      if (is_pcmr && we_i) begin
        pcmr_q <= wdata_i[1:0];
      end
    end
  end

  // zero when neither register is addressed
  always_comb begin
    rdata_o = '0;
    if (is_pcer) begin
      rdata_o[N_PERF_COUNTERS-1:0] = pcer_q;
    end else if (is_pcmr) begin
      rdata_o[1:0] = pcmr_q;
    end
  end

  assign pcer_o = pcer_q;
  assign pcmr_o = pcmr_q;

endmodule

// ==== source/perf_counter_bank.sv ====
// Performance counter bank.
// Conditions the core events, registers one increment per counter and
// updates the 32-bit counters with optional saturation. CSR accesses
// to 780+i, or 79F for all counters, act on the counters directly.

module perf_counter_bank #(
  parameter int N_EXT_CNT       = 2,
  parameter int N_PERF_COUNTERS = 12
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  csr_pkg::csr_req_t          csr_req_i,
  input  csr_pkg::perf_event_t       events_i,
  input  logic [N_EXT_CNT-1:0]       ext_events_i,
  input  logic [N_PERF_COUNTERS-1:0] pcer_i,
  input  logic [1:0]                 pcmr_i,
  output logic [31:0]                rdata_o
);

  logic                             id_valid_q;
  logic [N_PERF_COUNTERS-1:0]       cnt_in;
  logic [N_PERF_COUNTERS-1:0]       cnt_inc;
  logic [N_PERF_COUNTERS-1:0]       cnt_inc_q;
  logic [N_PERF_COUNTERS-1:0][31:0] cnt_q, cnt_n;
  logic                             is_pccr;
  logic                             sel_all;
  logic [4:0]                       pccr_idx;

  //////////////////////////////////////////////////////////////////////
  // event conditioning
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    cnt_in = '0;
    cnt_in[csr_pkg::EV_CYCLE]        = 1'b1;
    cnt_in[csr_pkg::EV_INSTR]        = events_i.id_valid & events_i.is_decoding;
    // hazard and control flow events qualified by last cycle's id_valid
    cnt_in[csr_pkg::EV_LD_STALL]     = events_i.ld_stall & id_valid_q;
    // fetch wait, not counting refetch after a jump or branch
    cnt_in[csr_pkg::EV_IMISS]        = events_i.imiss & ~events_i.pc_set;
    cnt_in[csr_pkg::EV_LOAD]         = events_i.mem_load;
    cnt_in[csr_pkg::EV_STORE]        = events_i.mem_store;
    cnt_in[csr_pkg::EV_JUMP]         = events_i.jump & id_valid_q;
    cnt_in[csr_pkg::EV_BRANCH]       = events_i.branch & id_valid_q;
    cnt_in[csr_pkg::EV_BRANCH_TAKEN] = events_i.branch & events_i.branch_taken & id_valid_q;
    cnt_in[csr_pkg::EV_COMPRESSED]   = events_i.id_valid & events_i.is_decoding &
                                       events_i.is_compressed;
    cnt_in[csr_pkg::N_FIXED_EVENTS +: N_EXT_CNT] = ext_events_i;
  end

  // event, its enable and the global enable
  assign cnt_inc = cnt_in & pcer_i & {N_PERF_COUNTERS{pcmr_i[0]}};

  //////////////////////////////////////////////////////////////////////
  // counter access and update
  //////////////////////////////////////////////////////////////////////

  assign is_pccr  = csr_req_i.access && (csr_req_i.addr[11:5] == csr_pkg::CSR_PCCR_BASE[11:5]);
  assign sel_all  = is_pccr && (csr_req_i.addr == csr_pkg::CSR_PCCR_ALL);
  assign pccr_idx = csr_req_i.addr[4:0];

  // slot 31 has no counter and reads zero
  always_comb begin
    rdata_o = '0;
    for (int i = 0; i < N_PERF_COUNTERS; i++) begin
      if (is_pccr && (pccr_idx == 5'(i))) begin
        rdata_o = cnt_q[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < N_PERF_COUNTERS; i++) begin
      cnt_n[i] = cnt_q[i];
      // stop at all ones when saturating, else wrap
      if (cnt_inc_q[i] && ((cnt_q[i] != 32'hFFFFFFFF) || !pcmr_i[1])) begin
        cnt_n[i] = cnt_q[i] + 32'd1;
      end
      // csr access replaces this cycle's increment
      if (sel_all || (is_pccr && (pccr_idx == 5'(i)))) begin
        case (csr_req_i.op)
          csr_pkg::CSR_OP_WRITE: cnt_n[i] = csr_req_i.wdata;
          csr_pkg::CSR_OP_SET:   cnt_n[i] = csr_req_i.wdata | cnt_q[i];
          csr_pkg::CSR_OP_CLEAR: cnt_n[i] = cnt_q[i] & ~csr_req_i.wdata;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      cnt_inc_q  <= '0;
      cnt_q      <= '0;
    end else begin
      id_valid_q <= events_i.id_valid;
      cnt_inc_q  <= cnt_inc;
      cnt_q      <= cnt_n;
    end
  end

endmodule

// ==== source/csr_file_top.sv ====
// Machine-mode CSR file top level.
// Instantiates the operation unit, the trap registers and the
// performance counter blocks, and selects the read data.
// Read data is combinational; writes land at the next rising edge.

module csr_file_top #(
  parameter int N_EXT_CNT = 2
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_pkg::csr_req_t    csr_req_i,
  output logic [31:0]          csr_rdata_o,
  input  csr_pkg::trap_ctrl_t  trap_i,
  input  logic [23:0]          boot_addr_i,
  input  logic [3:0]           core_id_i,
  input  logic [5:0]           cluster_id_i,
  input  csr_pkg::perf_event_t events_i,
  input  logic [N_EXT_CNT-1:0] ext_events_i,
  output logic [31:0]          epc_o,
  output logic [23:0]          tvec_o,
  output logic                 irq_enable_o,
  output logic                 csr_busy_o,
  output csr_pkg::priv_lvl_e   priv_lvl_o
);

  localparam int N_PERF_COUNTERS = csr_pkg::N_FIXED_EVENTS + N_EXT_CNT;

  logic [31:0]                wdata_eff;
  logic                       we;
  logic [31:0]                mach_rdata;
  logic [31:0]                cfg_rdata;
  logic [31:0]                cnt_rdata;
  logic [N_PERF_COUNTERS-1:0] pcer;
  logic [1:0]                 pcmr;
  logic                       is_perf;

  //////////////////////////////////////////////////////////////////////
  // read select
  //////////////////////////////////////////////////////////////////////

  // counter window 780..79F plus PCER and PCMR
  assign is_perf = csr_req_i.access &&
                   ((csr_req_i.addr[11:5] == csr_pkg::CSR_PCCR_BASE[11:5]) ||
                    (csr_req_i.addr == csr_pkg::CSR_PCER) ||
                    (csr_req_i.addr == csr_pkg::CSR_PCMR));

  // the perf blocks return zero when not addressed
  assign csr_rdata_o = is_perf ? (cfg_rdata | cnt_rdata) : mach_rdata;

  csr_op_unit csr_op_unit_inst (
    .csr_req_i (csr_req_i),
    .rdata_i   (csr_rdata_o),
    .wdata_o   (wdata_eff),
    .we_o      (we)
  );

  machine_trap_regs machine_trap_regs_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .addr_i       (csr_req_i.addr),
    .wdata_i      (wdata_eff),
    .we_i         (we),
    .trap_i       (trap_i),
    .boot_addr_i  (boot_addr_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .rdata_o      (mach_rdata),
    .epc_o        (epc_o),
    .tvec_o       (tvec_o),
    .irq_enable_o (irq_enable_o),
    .csr_busy_o   (csr_busy_o),
    .priv_lvl_o   (priv_lvl_o)
  );

  perf_config_regs #(
    .N_PERF_COUNTERS (N_PERF_COUNTERS)
  ) perf_config_regs_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .addr_i   (csr_req_i.addr),
    .access_i (csr_req_i.access),
    .wdata_i  (wdata_eff),
    .we_i     (we),
    .pcer_o   (pcer),
    .pcmr_o   (pcmr),
    .rdata_o  (cfg_rdata)
  );

  perf_counter_bank #(
    .N_EXT_CNT       (N_EXT_CNT),
    .N_PERF_COUNTERS (N_PERF_COUNTERS)
  ) perf_counter_bank_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_req_i    (csr_req_i),
    .events_i     (events_i),
    .ext_events_i (ext_events_i),
    .pcer_i       (pcer),
    .pcmr_i       (pcmr),
    .rdata_o      (cnt_rdata)
  );

endmodule

// ==== tests/csr_test_table.svh ====
// CSR access sequences for the CSR file testbench.
// Each entry is one request cycle and then a read of the same CSR.
// columns: name, op, addr, wdata, expected read-back
// mstatus starts at 1800 and mtvec follows a boot address of 1C0000.

  task automatic load_access_table();
    // mstatus, only mie and mpie are writable
    add_entry("mstatus_write", csr_pkg::CSR_OP_WRITE, 12'h300, 32'h0000_0088, 32'h0000_1888);
    add_entry("mstatus_clear", csr_pkg::CSR_OP_CLEAR, 12'h300, 32'h0000_0008, 32'h0000_1880);
    add_entry("mstatus_set", csr_pkg::CSR_OP_SET, 12'h300, 32'h0000_0008, 32'h0000_1888);
    add_entry("mstatus_none", csr_pkg::CSR_OP_NONE, 12'h300, 32'hFFFF_FFFF, 32'h0000_1888);
    add_entry("mstatus_clr_all", csr_pkg::CSR_OP_CLEAR, 12'h300, 32'hFFFF_FFFF, 32'h0000_1800);
    // mepc, full 32 bits
    add_entry("mepc_write", csr_pkg::CSR_OP_WRITE, 12'h341, 32'h1234_5678, 32'h1234_5678);
    add_entry("mepc_set", csr_pkg::CSR_OP_SET, 12'h341, 32'h0000_F00F, 32'h1234_F67F);
    add_entry("mepc_clear", csr_pkg::CSR_OP_CLEAR, 12'h341, 32'hFF00_0000, 32'h0034_F67F);
    add_entry("mepc_none", csr_pkg::CSR_OP_NONE, 12'h341, 32'h0000_0000, 32'h0034_F67F);
    // mcause keeps bit 31 and bits 4:0
    add_entry("mcause_write", csr_pkg::CSR_OP_WRITE, 12'h342, 32'h8000_001B, 32'h8000_001B);
    add_entry("mcause_clear", csr_pkg::CSR_OP_CLEAR, 12'h342, 32'h8000_0000, 32'h0000_001B);
    // read only
    add_entry("misa_write", csr_pkg::CSR_OP_WRITE, 12'h301, 32'hFFFF_FFFF, 32'h0000_0000);
    add_entry("mtvec_write", csr_pkg::CSR_OP_WRITE, 12'h305, 32'hFFFF_FFFF, 32'h1C00_0000);
    // perf config, 12 event enables
    add_entry("pcer_write", csr_pkg::CSR_OP_WRITE, 12'h7A0, 32'hFFFF_FFFF, 32'h0000_0FFF);
    add_entry("pcer_clear", csr_pkg::CSR_OP_CLEAR, 12'h7A0, 32'h0000_0FF0, 32'h0000_000F);
    add_entry("pcer_zero", csr_pkg::CSR_OP_WRITE, 12'h7A0, 32'h0000_0000, 32'h0000_0000);
    add_entry("pcmr_clear", csr_pkg::CSR_OP_CLEAR, 12'h7A1, 32'h0000_0001, 32'h0000_0002);
    add_entry("pcmr_set", csr_pkg::CSR_OP_SET, 12'h7A1, 32'h0000_0001, 32'h0000_0003);
    // store counter never counts here
    add_entry("pccr5_write", csr_pkg::CSR_OP_WRITE, 12'h785, 32'hCAFE_0000, 32'hCAFE_0000);
    add_entry("pccr5_set", csr_pkg::CSR_OP_SET, 12'h785, 32'h0000_00A5, 32'hCAFE_00A5);
    add_entry("pccr5_clear", csr_pkg::CSR_OP_CLEAR, 12'h785, 32'hFFFF_FFFF, 32'h0000_0000);
  endtask

// ==== tests/csr_file_tb.sv ====
// Testbench for the machine-mode CSR file.
// Checks reset values, a table of CSR accesses, trap entry, MRET and
// the performance counters. Mismatches are counted and summed up at
// the end of the run.

module csr_file_tb;

  localparam int          N_EXT_CNT    = 2;
  localparam int          N_COUNTERS   = csr_pkg::N_FIXED_EVENTS + N_EXT_CNT;
  localparam logic [23:0] BOOT_ADDR    = 24'h1C0000;
  localparam logic [3:0]  CORE_ID      = 4'h5;
  localparam logic [5:0]  CLUSTER_ID   = 6'h2A;
  localparam int          MAX_WAIT     = 16;
  localparam int          INSTR_CYCLES = 7;
  localparam int          EXT_CYCLES   = 20;

  logic                 clk;
  logic                 rst_n;
  csr_pkg::csr_req_t    csr_req;
  logic [31:0]          csr_rdata;
  csr_pkg::trap_ctrl_t  trap;
  logic [23:0]          boot_addr;
  logic [3:0]           core_id;
  logic [5:0]           cluster_id;
  csr_pkg::perf_event_t events;
  logic [N_EXT_CNT-1:0] ext_events;
  logic [31:0]          epc;
  logic [23:0]          tvec;
  logic                 irq_enable;
  logic                 csr_busy;
  csr_pkg::priv_lvl_e   priv_lvl;

  int     errors;
  integer seed;

  // access table, filled from the header
  string            tbl_name[$];
  csr_pkg::csr_op_e tbl_op[$];
  logic [11:0]      tbl_addr[$];
  logic [31:0]      tbl_wdata[$];
  logic [31:0]      tbl_expect[$];

  csr_file_top #(
    .N_EXT_CNT (N_EXT_CNT)
  ) csr_file_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_req_i    (csr_req),
    .csr_rdata_o  (csr_rdata),
    .trap_i       (trap),
    .boot_addr_i  (boot_addr),
    .core_id_i    (core_id),
    .cluster_id_i (cluster_id),
    .events_i     (events),
    .ext_events_i (ext_events),
    .epc_o        (epc),
    .tvec_o       (tvec),
    .irq_enable_o (irq_enable),
    .csr_busy_o   (csr_busy),
    .priv_lvl_o   (priv_lvl)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////

  task automatic add_entry(input string name, input csr_pkg::csr_op_e op,
                           input logic [11:0] addr, input logic [31:0] wdata,
                           input logic [31:0] expected);
    tbl_name.push_back(name);
    tbl_op.push_back(op);
    tbl_addr.push_back(addr);
    tbl_wdata.push_back(wdata);
    tbl_expect.push_back(expected);
  endtask

  `include "csr_test_table.svh"

  // rising edge plus the drive delay
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic set_request(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                             input logic [31:0] wdata);
    csr_req.access = 1'b1;
    csr_req.addr   = addr;
    csr_req.wdata  = wdata;
    csr_req.op     = op;
  endtask

  // one request cycle, then back to idle
  task automatic write_csr(input csr_pkg::csr_op_e op, input logic [11:0] addr,
                           input logic [31:0] wdata);
    set_request(op, addr, wdata);
    next_cycle();
    csr_req = '0;
  endtask

  // read data is combinational, sampled mid cycle
  task automatic read_csr(input logic [11:0] addr, output logic [31:0] data);
    set_request(csr_pkg::CSR_OP_NONE, addr, 32'h0);
    @(negedge clk);
    data = csr_rdata;
    next_cycle();
    csr_req = '0;
  endtask

  task automatic expect_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Error: %s expected %08h actual %08h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic expect_flag(input string name, input logic expected, input logic actual);
    expect_value(name, {31'b0, expected}, {31'b0, actual});
  endtask

  task automatic check_csr(input string name, input logic [11:0] addr,
                           input logic [31:0] expected);
    logic [31:0] data;
    read_csr(addr, data);
    expect_value(name, expected, data);
  endtask

  // poll a counter until it holds the expected count
  task automatic await_count(input string name, input int idx, input logic [31:0] expected);
    logic [31:0] data;
    logic [11:0] addr;
    int          cycles;
    addr   = csr_pkg::CSR_PCCR_BASE + 12'(idx);
    cycles = 0;
    read_csr(addr, data);
    while ((data !== expected) && (cycles < MAX_WAIT)) begin
      read_csr(addr, data);
      cycles++;
    end
    assert (data === expected) else begin
      $display("%s did not reach %0d within %0d cycles, last value %0d",
               name, expected, MAX_WAIT, data);
      errors++;
    end
    // events are idle now, count must not move
    check_csr($sformatf("%s_hold", name), addr, expected);
  endtask

  ////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] rnd;
    logic [31:0] exp_pc;
    logic [31:0] exp_cause;
    logic [5:0]  cause;
    logic        exp_busy;
    int          ext_ones [N_EXT_CNT];

    errors     = 0;
    seed       = 32'h2008ec6f;
    clk        = 1'b0;
    rst_n      = 1'b0;
    csr_req    = '0;
    trap       = '0;
    events     = '0;
    ext_events = '0;
    boot_addr  = BOOT_ADDR;
    core_id    = CORE_ID;
    cluster_id = CLUSTER_ID;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset state
    check_csr("reset_mstatus", csr_pkg::CSR_MSTATUS, 32'h0000_1800);
    check_csr("reset_mtvec", csr_pkg::CSR_MTVEC, {BOOT_ADDR, 8'h00});
    check_csr("reset_mhartid", csr_pkg::CSR_MHARTID,
              (32'(CLUSTER_ID) << 5) | 32'(CORE_ID));
    check_csr("reset_privlv", csr_pkg::CSR_PRIVLV, 32'd3);
    check_csr("reset_pcmr", csr_pkg::CSR_PCMR, 32'd3);
    check_csr("reset_pcer", csr_pkg::CSR_PCER, 32'd0);
    for (int i = 0; i < N_COUNTERS; i++) begin
      check_csr($sformatf("reset_pccr%0d", i), csr_pkg::CSR_PCCR_BASE + 12'(i), 32'd0);
    end
    expect_value("reset_tvec_o", {8'h00, BOOT_ADDR}, {8'h00, tvec});
    expect_value("reset_priv_lvl_o", 32'd3, {30'b0, priv_lvl});
    expect_flag("reset_csr_busy", 1'b0, csr_busy);
    expect_flag("reset_irq_enable", 1'b0, irq_enable);

    // table of accesses, busy only while mepc is written
    load_access_table();
    for (int i = 0; i < tbl_name.size(); i++) begin
      exp_busy = (tbl_addr[i] == csr_pkg::CSR_MEPC) && (tbl_op[i] != csr_pkg::CSR_OP_NONE);
      set_request(tbl_op[i], tbl_addr[i], tbl_wdata[i]);
      @(negedge clk);
      expect_flag($sformatf("%s_busy", tbl_name[i]), exp_busy, csr_busy);
      next_cycle();
      set_request(csr_pkg::CSR_OP_NONE, tbl_addr[i], 32'h0);
      @(negedge clk);
      expect_value(tbl_name[i], tbl_expect[i], csr_rdata);
      expect_flag($sformatf("%s_read_busy", tbl_name[i]), 1'b0, csr_busy);
      next_cycle();
      csr_req = '0;
    end

    // trap entry from if, id and ex, racing a mepc write
    for (int s = 0; s < 3; s++) begin
      write_csr(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MSTATUS, 32'h0000_0008);
      check_csr($sformatf("trap%0d_pre_mstatus", s), csr_pkg::CSR_MSTATUS, 32'h0000_1808);
      expect_flag($sformatf("trap%0d_pre_irq", s), 1'b1, irq_enable);
      cause              = (s == 1) ? 6'h2B : 6'(11 + s);
      // cause bit 5 reads back in bit 31
      exp_cause          = (s == 1) ? 32'h8000_000B : 32'(11 + s);
      trap.save_cause    = 1'b1;
      trap.save_if       = (s == 0);
      trap.save_id       = (s != 0);
      trap.load_event_ex = (s == 2);
      trap.cause         = cause;
      trap.pc_if         = 32'h1C00_0100;
      trap.pc_id         = 32'h1C00_0204;
      trap.pc_ex         = 32'h1C00_0308;
      // ex stage wins, then if, else id
      exp_pc = (s == 2) ? trap.pc_ex : ((s == 0) ? trap.pc_if : trap.pc_id);
      set_request(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MEPC, 32'hDEAD_BEEF);
      next_cycle();
      trap    = '0;
      csr_req = '0;
      check_csr($sformatf("trap%0d_mepc", s), csr_pkg::CSR_MEPC, exp_pc);
      expect_value($sformatf("trap%0d_epc_o", s), exp_pc, epc);
      check_csr($sformatf("trap%0d_mcause", s), csr_pkg::CSR_MCAUSE, exp_cause);
      check_csr($sformatf("trap%0d_mstatus", s), csr_pkg::CSR_MSTATUS, 32'h0000_1880);
      expect_flag($sformatf("trap%0d_irq", s), 1'b0, irq_enable);
    end

    // mret, mie from mpie and mpie set
    trap.restore_mret = 1'b1;
    next_cycle();
    trap = '0;
    check_csr("mret_mstatus", csr_pkg::CSR_MSTATUS, 32'h0000_1888);
    expect_flag("mret_irq", 1'b1, irq_enable);
    write_csr(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_MSTATUS, 32'h0000_0000);
    trap.restore_mret = 1'b1;
    next_cycle();
    trap = '0;
    check_csr("mret_low_mstatus", csr_pkg::CSR_MSTATUS, 32'h0000_1880);
    expect_flag("mret_low_irq", 1'b0, irq_enable);

    // trap with mie low, mpie takes the cleared mie
    trap.save_cause = 1'b1;
    trap.save_id    = 1'b1;
    trap.cause      = 6'h03;
    trap.pc_id      = 32'h1C00_0410;
    next_cycle();
    trap = '0;
    check_csr("trap_low_mstatus", csr_pkg::CSR_MSTATUS, 32'h0000_1800);

    // instruction counter
    write_csr(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PCER, 32'h1 << csr_pkg::EV_INSTR);
    write_csr(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PCCR_BASE + 12'(csr_pkg::EV_INSTR), 32'h0);
    for (int k = 0; k < INSTR_CYCLES; k++) begin
      events.id_valid    = 1'b1;
      events.is_decoding = 1'b1;
      next_cycle();
    end
    events = '0;
    await_count("instr_count", csr_pkg::EV_INSTR, 32'(INSTR_CYCLES));

    // external events, count set bits per input
    write_csr(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PCER, 32'h3 << csr_pkg::N_FIXED_EVENTS);
    write_csr(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PCCR_ALL, 32'h0);
    for (int b = 0; b < N_EXT_CNT; b++) begin
      ext_ones[b] = 0;
    end
    for (int k = 0; k < EXT_CYCLES; k++) begin
      rnd        = $random(seed);
      ext_events = rnd[N_EXT_CNT-1:0];
      for (int b = 0; b < N_EXT_CNT; b++) begin
        if (rnd[b]) begin
          ext_ones[b]++;
        end
      end
      next_cycle();
    end
    ext_events = '0;
    for (int b = 0; b < N_EXT_CNT; b++) begin
      await_count($sformatf("ext%0d_count", b), csr_pkg::N_FIXED_EVENTS + b,
                  32'(ext_ones[b]));
    end

    // saturation on, cycle counter sticks at all ones
    write_csr(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PCER, 32'h1 << csr_pkg::EV_CYCLE);
    write_csr(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PCCR_BASE, 32'hFFFF_FFFF);
    for (int k = 0; k < 4; k++) begin
      check_csr($sformatf("sat_hold%0d", k), csr_pkg::CSR_PCCR_BASE, 32'hFFFF_FFFF);
    end

    // saturation off, one counted cycle wraps to zero
    write_csr(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PCMR, 32'h1);
    write_csr(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PCCR_BASE, 32'hFFFF_FFFF);
    check_csr("wrap_written", csr_pkg::CSR_PCCR_BASE, 32'hFFFF_FFFF);
    check_csr("wrap_zero", csr_pkg::CSR_PCCR_BASE, 32'h0);

    // 79F writes every counter
    write_csr(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PCER, 32'h0);
    write_csr(csr_pkg::CSR_OP_WRITE, csr_pkg::CSR_PCCR_ALL, 32'h5A5A_0005);
    for (int i = 0; i < N_COUNTERS; i++) begin
      check_csr($sformatf("all_pccr%0d", i), csr_pkg::CSR_PCCR_BASE + 12'(i), 32'h5A5A_0005);
    end

    $display("checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+tests
source/csr_pkg.sv
source/csr_op_unit.sv
source/machine_trap_regs.sv
source/perf_config_regs.sv
source/perf_counter_bank.sv
source/csr_file_top.sv
tests/csr_file_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = csr_file_tb
FILELIST  = verilog.f

.PHONY: sim clean

# build, run, and pass only if the pass message shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf obj_dir
